/* logic/cam_macros.svh */
`ifndef CAM_MACROS_SVH
`define CAM_MACROS_SVH

// ----------------------------------------
// horizontal raster, in clk cycles
// ----------------------------------------
`define CAM_H_ACTIVE    8   // visible pixels per line
`define CAM_H_FP        2
`define CAM_H_SYNC      2
`define CAM_H_BP        2

// ----------------------------------------
// vertical raster, in lines
// ----------------------------------------
`define CAM_V_ACTIVE    4   // visible lines per frame
`define CAM_V_FP        1
`define CAM_V_SYNC      1
`define CAM_V_BP        1

`define CAM_FIFO_DEPTH  16  // entries, also initial credits

`define CAM_RST_RELEASE 20  // cycles until sensor leaves reset
`define CAM_CFG_START   40  // cycles until configuration may begin

`endif

/* logic/cam_pkg.sv */
package cam_pkg;

    // sensor pixel as it comes off the byte pair packer
    typedef struct packed {
        logic [4:0] red;    // high bits
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // one pixel word, read raw or split into colours
    typedef union packed {
        logic [15:0] raw;
        rgb565_t     fields;
    } pixel_word_t;

    // display side colour, 8 bits per channel
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888_t;

endpackage

/* logic/sensor_power_seq.sv */
`include "cam_macros.svh"

module sensor_power_seq (
    input  logic clk,
    input  logic rst_n,
    output logic sensor_rst_n,
    output logic config_start
);

    localparam int CNT_W = $clog2(`CAM_CFG_START + 1);

    logic [CNT_W-1:0] delay_cnt;    // cycles since reset release

    // counter stops once the later event is reached, both levels then hold
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            delay_cnt    <= '0;
            sensor_rst_n <= 1'b0;   // sensor held in reset
            config_start <= 1'b0;
        end
        else
        begin
            if (delay_cnt != CNT_W'(`CAM_CFG_START))
            begin
                delay_cnt <= delay_cnt + 1'b1;  // saturating
            end
            if (delay_cnt == CNT_W'(`CAM_RST_RELEASE - 1))
            begin
                sensor_rst_n <= 1'b1;           // high on cycle RST_RELEASE
            end
            if (delay_cnt == CNT_W'(`CAM_CFG_START - 1))
            begin
                config_start <= 1'b1;           // high on cycle CFG_START
            end
        end
    end

endmodule

/* logic/byte_pair_packer.sv */
`include "cam_macros.svh"

module byte_pair_packer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cam_href,
    input  logic                cam_byte_valid,
    input  logic [7:0]          cam_db,
    input  logic                credit_return,
    output logic                push,
    output cam_pkg::pixel_word_t push_pixel,
    output logic                overflow
);

    localparam int CRED_W = $clog2(`CAM_FIFO_DEPTH + 1);

    logic              byte_ok;     // byte strobe inside a line
    logic              phase;       // 1 = high byte already held
    logic              pair_done;
    logic              have_credit;
    logic              spend;
    logic [7:0]        hi_byte;
    logic [CRED_W-1:0] credits;     // free FIFO slots seen by the packer

    assign byte_ok     = cam_href & cam_byte_valid;
    assign pair_done   = byte_ok & phase;
    assign have_credit = (credits != '0);
    assign spend       = pair_done & have_credit;

    // ----------------------------------------
    // pair phase, credits, overflow
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase    <= 1'b0;
            push     <= 1'b0;
            credits  <= CRED_W'(`CAM_FIFO_DEPTH);
            overflow <= 1'b0;
        end
        else
        begin
            push <= spend;                          // one cycle after 2nd byte
            if (!cam_href)
                phase <= 1'b0;                      // realign on every line
            else if (byte_ok)
                phase <= ~phase;
            credits <= credits + CRED_W'(credit_return) - CRED_W'(spend);
            if (pair_done && !have_credit)
                overflow <= 1'b1;                   // pixel lost, sticky
        end
    end

    // payload path
    always_ff @(posedge clk)
    begin
        if (byte_ok && !phase)
            hi_byte <= cam_db;
        if (pair_done)
            push_pixel.raw <= {hi_byte, cam_db};    // first byte is the high half
    end

endmodule

/* logic/pixel_line_fifo.sv */
`include "cam_macros.svh"

module pixel_line_fifo (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  cam_pkg::pixel_word_t push_pixel,
    input  logic                 pop,
    output cam_pkg::pixel_word_t pop_pixel,
    output logic                 not_empty,
    output logic                 credit_return
);

    import cam_pkg::*;

    localparam int PTR_W = $clog2(`CAM_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`CAM_FIFO_DEPTH + 1);

    pixel_word_t      mem [`CAM_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;    // occupied entries

    assign pop_pixel = mem[rd_ptr];     // show-ahead read
    assign not_empty = (count != '0);

    // no full check here, the packer's credits keep pushes in bounds
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_pixel;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(`CAM_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(`CAM_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_return <= pop;   // slot freed, tell the packer
        end
    end

endmodule

/* logic/raster_timing_gen.sv */
`include "cam_macros.svh"

module raster_timing_gen (
    input  logic clk,
    input  logic rst_n,
    output logic raw_hs,
    output logic raw_vs,
    output logic raw_de
);

    localparam int H_TOTAL      = `CAM_H_ACTIVE + `CAM_H_FP + `CAM_H_SYNC + `CAM_H_BP;
    localparam int H_SYNC_START = `CAM_H_ACTIVE + `CAM_H_FP;
    localparam int H_SYNC_END   = H_SYNC_START + `CAM_H_SYNC;
    localparam int V_TOTAL      = `CAM_V_ACTIVE + `CAM_V_FP + `CAM_V_SYNC + `CAM_V_BP;
    localparam int V_SYNC_START = `CAM_V_ACTIVE + `CAM_V_FP;
    localparam int V_SYNC_END   = V_SYNC_START + `CAM_V_SYNC;
    localparam int HW           = $clog2(H_TOTAL);
    localparam int VW           = $clog2(V_TOTAL);

    logic [HW-1:0] h_cnt;   // pixel within line
    logic [VW-1:0] v_cnt;   // line within frame
    logic          line_end;

    assign line_end = (h_cnt == HW'(H_TOTAL - 1));

    // ----------------------------------------
    // counters, frame starts in vertical blanking
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_cnt <= '0;
            v_cnt <= VW'(`CAM_V_ACTIVE);    // gives the FIFO time to fill
        end
        else
        begin
            h_cnt <= line_end ? '0 : h_cnt + 1'b1;
            if (line_end)
                v_cnt <= (v_cnt == VW'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end
    end

    // active, front porch, sync, back porch
    assign raw_hs = !((h_cnt >= HW'(H_SYNC_START)) && (h_cnt < HW'(H_SYNC_END)));
    assign raw_vs = !((v_cnt >= VW'(V_SYNC_START)) && (v_cnt < VW'(V_SYNC_END)));
    assign raw_de = (h_cnt < HW'(`CAM_H_ACTIVE)) && (v_cnt < VW'(`CAM_V_ACTIVE));

endmodule

/* logic/pixel_out_stage.sv */
module pixel_out_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 raw_hs,
    input  logic                 raw_vs,
    input  logic                 raw_de,
    input  logic                 not_empty,
    input  cam_pkg::pixel_word_t pop_pixel,
    output logic                 pop,
    output logic                 hs_out,
    output logic                 vs_out,
    output logic                 de_out,
    output cam_pkg::rgb888_t     rgb_out,
    output logic                 underrun
);

    import cam_pkg::*;

    logic    hs_d1;
    logic    vs_d1;
    logic    de_d1;
    rgb888_t pix_wide;  // popped pixel or black
    rgb888_t pix_d1;

    assign pop = raw_de & not_empty;

    always_comb
    begin
        pix_wide = '0;  // blanking and empty FIFO both give black
        if (pop)
        begin
            pix_wide.red   = {pop_pixel.fields.red,   3'b000};
            pix_wide.green = {pop_pixel.fields.green, 2'b00};
            pix_wide.blue  = {pop_pixel.fields.blue,  3'b000};
        end
    end

    // two stage pipe, syncs idle high
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            {hs_d1, hs_out} <= 2'b11;
            {vs_d1, vs_out} <= 2'b11;
            {de_d1, de_out} <= 2'b00;
            pix_d1          <= '0;
            rgb_out         <= '0;
            underrun        <= 1'b0;
        end
        else
        begin
            {hs_d1, hs_out} <= {raw_hs, hs_d1};
            {vs_d1, vs_out} <= {raw_vs, vs_d1};
            {de_d1, de_out} <= {raw_de, de_d1};
            pix_d1          <= pix_wide;
            rgb_out         <= pix_d1;
            if (raw_de && !not_empty)
                underrun <= 1'b1;   // display outran the sensor, sticky
        end
    end

endmodule

/* logic/cam_display_top.sv */
module cam_display_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cam_href,
    input  logic             cam_byte_valid,
    input  logic [7:0]       cam_db,
    output logic             sensor_rst_n,
    output logic             config_start,
    output logic             hs_out,
    output logic             vs_out,
    output logic             de_out,
    output cam_pkg::rgb888_t rgb_out,
    output logic             overflow,
    output logic             underrun
);

    import cam_pkg::*;

    // ----------------------------------------
    // camera side
    // ----------------------------------------
    logic        push;
    pixel_word_t push_pixel;
    logic        credit_return;     // one per freed FIFO slot

    // ----------------------------------------
    // display side
    // ----------------------------------------
    logic        pop;
    pixel_word_t pop_pixel;
    logic        not_empty;
    logic        raw_hs;
    logic        raw_vs;
    logic        raw_de;

    sensor_power_seq u_power_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .sensor_rst_n (sensor_rst_n),
        .config_start (config_start)
    );

    byte_pair_packer u_packer (
        .clk            (clk),
        .rst_n          (rst_n),
        .cam_href       (cam_href),
        .cam_byte_valid (cam_byte_valid),
        .cam_db         (cam_db),
        .credit_return  (credit_return),
        .push           (push),
        .push_pixel     (push_pixel),
        .overflow       (overflow)
    );

    pixel_line_fifo u_line_fifo (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (push),
        .push_pixel    (push_pixel),
        .pop           (pop),
        .pop_pixel     (pop_pixel),
        .not_empty     (not_empty),
        .credit_return (credit_return)
    );

    raster_timing_gen u_timing (
        .clk    (clk),
        .rst_n  (rst_n),
        .raw_hs (raw_hs),
        .raw_vs (raw_vs),
        .raw_de (raw_de)
    );

    pixel_out_stage u_out_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .raw_hs    (raw_hs),
        .raw_vs    (raw_vs),
        .raw_de    (raw_de),
        .not_empty (not_empty),
        .pop_pixel (pop_pixel),
        .pop       (pop),
        .hs_out    (hs_out),
        .vs_out    (vs_out),
        .de_out    (de_out),
        .rgb_out   (rgb_out),
        .underrun  (underrun)
    );

endmodule

/* test/cam_display_checker.sv */
`include "cam_macros.svh"

module cam_display_checker (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cam_href,
    input  logic             cam_byte_valid,
    input  logic [7:0]       cam_db,
    input  logic             raw_de,
    input  logic             sensor_rst_n,
    input  logic             config_start,
    input  logic             hs_out,
    input  logic             vs_out,
    input  logic             de_out,
    input  cam_pkg::rgb888_t rgb_out,
    input  logic             overflow,
    input  logic             underrun
);

    timeunit 1ns;
    timeprecision 1ps;

    import cam_pkg::*;

    localparam int H_TOTAL = `CAM_H_ACTIVE + `CAM_H_FP + `CAM_H_SYNC + `CAM_H_BP;
    localparam int V_TOTAL = `CAM_V_ACTIVE + `CAM_V_FP + `CAM_V_SYNC + `CAM_V_BP;

    int          fail_count = 0;    // read by the testbench
    logic [15:0] ref_q [$];         // accepted pixels, oldest first
    logic        m_phase;
    logic [7:0]  m_hi;
    int          m_credits;
    int          m_count;           // expected FIFO occupancy
    logic        m_push_d;          // write lands on the next edge
    logic        m_pop_d;           // credit pulse in flight
    logic        m_overflow;
    logic        m_underrun;
    rgb888_t     exp_d1;
    rgb888_t     exp_d2;            // expected rgb_out this cycle

    int          since_rst;
    int          hs_gap;
    int          vs_gap;
    int          de_run;
    int          de_lines;          // active lines since last vs fall
    logic        de_raw_d1;
    logic        de_raw_d2;         // raw_de two cycles back
    logic        hs_prev;
    logic        vs_prev;
    logic        de_prev;
    logic        hs_seen;
    logic        vs_seen;
    logic        hs_fall;
    logic        vs_fall;
    logic        de_fall;

    assign hs_fall = hs_prev && !hs_out;
    assign vs_fall = vs_prev && !vs_out;
    assign de_fall = de_prev && !de_out;

    // ----------------------------------------
    // reference pixel and credit model
    // ----------------------------------------
    always @(posedge clk or negedge rst_n)
    begin : ref_model
        logic        pair;
        logic        spend;
        logic        pop_now;
        logic [15:0] word;
        rgb888_t     exp_now;
        if (!rst_n)
        begin
            ref_q.delete();
            m_phase    <= 1'b0;
            m_hi       <= '0;
            m_credits  <= `CAM_FIFO_DEPTH;
            m_count    <= 0;
            m_push_d   <= 1'b0;
            m_pop_d    <= 1'b0;
            m_overflow <= 1'b0;
            m_underrun <= 1'b0;
            exp_d1     <= '0;
            exp_d2     <= '0;
        end
        else
        begin
            pair    = cam_href && cam_byte_valid && m_phase;
            spend   = pair && (m_credits > 0);
            pop_now = raw_de && (m_count > 0);
            exp_now = '0;                           // black unless a pixel leaves
            if (!cam_href)
                m_phase <= 1'b0;
            else if (cam_byte_valid)
                m_phase <= !m_phase;
            if (cam_href && cam_byte_valid && !m_phase)
                m_hi <= cam_db;                     // high half comes first
            if (pop_now)
            begin
                word          = ref_q.pop_front();
                exp_now.red   = {word[15:11], 3'b000};
                exp_now.green = {word[10:5], 2'b00};
                exp_now.blue  = {word[4:0], 3'b000};
            end
            if (spend)
                ref_q.push_back({m_hi, cam_db});
            if (pair && !spend)
                m_overflow <= 1'b1;
            if (raw_de && m_count == 0)
                m_underrun <= 1'b1;
            m_credits <= m_credits + int'(m_pop_d) - int'(spend);
            m_count   <= m_count + int'(m_push_d) - int'(pop_now);
            m_push_d  <= spend;
            m_pop_d   <= pop_now;
            exp_d1    <= exp_now;
            exp_d2    <= exp_d1;
        end
    end

    // interval and run counters for the timing checks
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            since_rst <= 0;
            hs_prev   <= 1'b1;
            vs_prev   <= 1'b1;
            de_prev   <= 1'b0;
            hs_seen   <= 1'b0;
            vs_seen   <= 1'b0;
            hs_gap    <= 0;
            vs_gap    <= 0;
            de_run    <= 0;
            de_lines  <= 0;
            de_raw_d1 <= 1'b0;
            de_raw_d2 <= 1'b0;
        end
        else
        begin
            if (since_rst <= `CAM_CFG_START)
                since_rst <= since_rst + 1;
            hs_prev   <= hs_out;
            vs_prev   <= vs_out;
            de_prev   <= de_out;
            de_raw_d1 <= raw_de;
            de_raw_d2 <= de_raw_d1;
            hs_gap    <= hs_fall ? 1 : hs_gap + 1;
            vs_gap    <= vs_fall ? 1 : vs_gap + 1;
            de_run    <= de_out ? de_run + 1 : 0;
            if (hs_fall)
                hs_seen <= 1'b1;
            if (vs_fall)
                vs_seen <= 1'b1;
            if (vs_fall)
                de_lines <= 0;
            else if (de_fall)
                de_lines <= de_lines + 1;
        end
    end

    // ----------------------------------------
    // assertions
    // ----------------------------------------
    a_reset_idle: assert property (@(posedge clk) !rst_n |-> (hs_out && vs_out && !de_out
            && !overflow && !underrun && !sensor_rst_n && !config_start))
        else
        begin
            fail_count++;
            $error("outputs not at their idle levels during reset at %0t", $time);
        end

    a_sensor_rst: assert property (@(posedge clk) disable iff (!rst_n)
            sensor_rst_n == (since_rst >= `CAM_RST_RELEASE))
        else
        begin
            fail_count++;
            $error("FAIL %0t sensor_rst_n exp %0b got %0b", $time,
                   $sampled(since_rst) >= `CAM_RST_RELEASE, $sampled(sensor_rst_n));
        end

    a_cfg_start: assert property (@(posedge clk) disable iff (!rst_n)
            config_start == (since_rst >= `CAM_CFG_START))
        else
        begin
            fail_count++;
            $error("FAIL %0t config_start exp %0b got %0b", $time,
                   $sampled(since_rst) >= `CAM_CFG_START, $sampled(config_start));
        end

    a_cfg_order: assert property (@(posedge clk) disable iff (!rst_n)
            config_start |-> sensor_rst_n)
        else
        begin
            fail_count++;
            $error("config_start high while the sensor is still in reset at %0t", $time);
        end

    a_hs_period: assert property (@(posedge clk) disable iff (!rst_n)
            hs_fall && hs_seen |-> hs_gap == H_TOTAL)
        else
        begin
            fail_count++;
            $error("FAIL %0t hs_out period exp %0d got %0d", $time, H_TOTAL, $sampled(hs_gap));
        end

    a_vs_period: assert property (@(posedge clk) disable iff (!rst_n)
            vs_fall && vs_seen |-> vs_gap == H_TOTAL * V_TOTAL)
        else
        begin
            fail_count++;
            $error("FAIL %0t vs_out period exp %0d got %0d", $time, H_TOTAL * V_TOTAL,
                   $sampled(vs_gap));
        end

    a_de_run: assert property (@(posedge clk) disable iff (!rst_n)
            de_fall |-> de_run == `CAM_H_ACTIVE)
        else
        begin
            fail_count++;
            $error("FAIL %0t de_out run exp %0d got %0d", $time, `CAM_H_ACTIVE,
                   $sampled(de_run));
        end

    a_de_lines: assert property (@(posedge clk) disable iff (!rst_n)
            vs_fall && vs_seen |-> de_lines == `CAM_V_ACTIVE)
        else
        begin
            fail_count++;
            $error("FAIL %0t de_out lines exp %0d got %0d", $time, `CAM_V_ACTIVE,
                   $sampled(de_lines));
        end

    a_de_delay: assert property (@(posedge clk) disable iff (!rst_n) de_out == de_raw_d2)
        else
        begin
            fail_count++;
            $error("FAIL %0t de_out exp %0b got %0b", $time, $sampled(de_raw_d2),
                   $sampled(de_out));
        end

    a_pixel: assert property (@(posedge clk) disable iff (!rst_n) rgb_out == exp_d2)
        else
        begin
            fail_count++;
            $error("FAIL %0t rgb_out exp %h got %h", $time, $sampled(exp_d2), $sampled(rgb_out));
        end

    a_blank: assert property (@(posedge clk) disable iff (!rst_n) !de_out |-> rgb_out == '0)
        else
        begin
            fail_count++;
            $error("FAIL %0t rgb_out exp 0 got %h outside de", $time, $sampled(rgb_out));
        end

    a_overflow: assert property (@(posedge clk) disable iff (!rst_n) overflow == m_overflow)
        else
        begin
            fail_count++;
            $error("FAIL %0t overflow exp %0b got %0b", $time, $sampled(m_overflow),
                   $sampled(overflow));
        end

    a_underrun: assert property (@(posedge clk) disable iff (!rst_n) underrun == m_underrun)
        else
        begin
            fail_count++;
            $error("FAIL %0t underrun exp %0b got %0b", $time, $sampled(m_underrun),
                   $sampled(underrun));
        end

endmodule

/* test/cam_display_tb.sv */
`include "cam_macros.svh"

module cam_display_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import cam_pkg::*;

    localparam int FRAME_CYCLES = (`CAM_H_ACTIVE + `CAM_H_FP + `CAM_H_SYNC + `CAM_H_BP)
                                * (`CAM_V_ACTIVE + `CAM_V_FP + `CAM_V_SYNC + `CAM_V_BP);
    localparam int TEST_FRAMES  = 3;                         // per test
    localparam int CYCLE_LIMIT  = 2 * 3 * TEST_FRAMES * FRAME_CYCLES;
    localparam int BURST_PIXELS = `CAM_FIFO_DEPTH + 2;

    logic       clk;
    logic       rst_n;
    logic       cam_href;
    logic       cam_byte_valid;
    logic [7:0] cam_db;
    logic       sensor_rst_n;
    logic       config_start;
    logic       hs_out;
    logic       vs_out;
    logic       de_out;
    rgb888_t    rgb_out;
    logic       overflow;
    logic       underrun;

    logic       streaming;
    int         cycles;
    int         tests_done;
    int         fails_seen;     // checker failures at the end of the last test

    cam_display_top dut (.*);

    bind cam_display_top cam_display_checker u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .cam_href       (cam_href),
        .cam_byte_valid (cam_byte_valid),
        .cam_db         (cam_db),
        .raw_de         (raw_de),
        .sensor_rst_n   (sensor_rst_n),
        .config_start   (config_start),
        .hs_out         (hs_out),
        .vs_out         (vs_out),
        .de_out         (de_out),
        .rgb_out        (rgb_out),
        .overflow       (overflow),
        .underrun       (underrun)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // starts 2 ns past an edge, or ahead of the first edge
    task automatic apply_reset();
        rst_n = 1'b0;   // asynchronous, DUT clears at once
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;   // now 2 ns past an edge
    endtask

    task automatic idle_camera();
        cam_href       = 1'b0;
        cam_byte_valid = 1'b0;
        cam_db         = '0;
    endtask

    task automatic wait_frames(input int n);
        repeat (n) @(negedge vs_out);
    endtask

    task automatic report_test(input string name);
        int now_fails;
        now_fails = dut.u_checker.fail_count;
        tests_done++;
        $display("test %s finished, %0d assertion failures", name, now_fails - fails_seen);
        fails_seen = now_fails;
    endtask

    // back to back bytes, all inside the first vertical blanking
    task automatic send_burst(input int pixels);
        for (int i = 0; i < 2 * pixels; i++)
        begin
            cam_href       = 1'b1;
            cam_byte_valid = 1'b1;
            cam_db         = 8'($urandom);
            next_cycle();
        end
        idle_camera();
    endtask

    // 20 byte slots per line, then 4 with href low
    task automatic drive_stream();
        int slot;
        slot = 0;
        while (streaming)
        begin
            cam_href       = (slot < 20);
            cam_byte_valid = (slot < 20) && ($urandom % 8 != 0);
            cam_db         = 8'($urandom);
            slot           = (slot == 23) ? 0 : slot + 1;
            next_cycle();
        end
        idle_camera();
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    initial
    begin
        void'($urandom(32'he376));
        rst_n      = 1'b1;
        idle_camera();
        streaming  = 1'b0;
        tests_done = 0;
        fails_seen = 0;
        #2;

        apply_reset();
        wait_frames(TEST_FRAMES);           // idle camera, so underrun too
        report_test("power_up_raster_underrun");

        next_cycle();
        apply_reset();
        send_burst(BURST_PIXELS);
        wait_frames(TEST_FRAMES);
        report_test("overflow_burst");

        next_cycle();
        apply_reset();
        streaming = 1'b1;
        fork
            drive_stream();
            begin
                wait_frames(TEST_FRAMES);
                streaming = 1'b0;
            end
        join
        report_test("pixel_stream");

        $display("tests run %0d, assertion failures %0d", tests_done, fails_seen);
        if (fails_seen == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles, tests did not finish in time", cycles);
        $display("Regression failed");
        $finish;
    end

endmodule

/* sim.f */
+incdir+logic
logic/cam_pkg.sv
logic/sensor_power_seq.sv
logic/byte_pair_packer.sv
logic/pixel_line_fifo.sv
logic/raster_timing_gen.sv
logic/pixel_out_stage.sv
logic/cam_display_top.sv
test/cam_display_checker.sv
test/cam_display_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cam_display_tb
FLIST    = sim.f
LOG      = sim.log
RUN_OPTS = +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(TOOL), run $(TOP), fail if $(LOG) reports failure"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) $(RUN_OPTS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
